// ==== build.f ====
hw/nib_regs_pkg.sv
hw/nib_bus_pkg.sv
hw/nib_regs.sv
hw/nib_alu.sv
hw/nib_sequencer.sv
hw/nib_data_ram.sv
hw/nib_core.sv
dv/nib_clkgen.sv
dv/nib_core_props.sv
dv/nib_core_tb.sv

// ==== dv/nib_clkgen.sv ====
`timescale 1ns/1ps

module nib_clkgen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release lands just after an edge, like the other inputs.
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

// ==== dv/nib_core_props.sv ====
`timescale 1ns/1ps

module nib_core_props (
  input  logic                    clk,
  input  logic                    rst,
  input  nib_bus_pkg::host_req_t  host_req,
  input  nib_bus_pkg::host_rsp_t  host_rsp,
  input  nib_bus_pkg::mem_req_t   mem_req,
  input  nib_bus_pkg::mem_rsp_t   mem_rsp,
  input  nib_regs_pkg::cycle_type cycle,
  input  nib_regs_pkg::reg_type   source,
  input  nib_regs_pkg::reg_type   destination
);

  int fail_count = 0;

  host_ack_with_stb: assert property (@(posedge clk) disable iff (rst)
    host_rsp.ack |-> host_req.cyc && host_req.stb)
    else begin
      fail_count++;
      $error("host ack seen without an active strobe");
    end

  host_ack_single: assert property (@(posedge clk) disable iff (rst)
    host_rsp.ack |=> !host_rsp.ack)
    else begin
      fail_count++;
      $error("host ack held for more than one cycle");
    end

  mem_ack_with_stb: assert property (@(posedge clk) disable iff (rst)
    mem_rsp.ack |-> mem_req.cyc && mem_req.stb)
    else begin
      fail_count++;
      $error("RAM ack seen without an active strobe");
    end

  mem_ack_single: assert property (@(posedge clk) disable iff (rst)
    mem_rsp.ack |=> !mem_rsp.ack)
    else begin
      fail_count++;
      $error("RAM ack held for more than one cycle");
    end

  // Bus idle right after reset.
  idle_after_reset: assert property (@(posedge clk)
    rst |=> !host_rsp.ack && !mem_req.stb && !mem_rsp.ack &&
            cycle == nib_regs_pkg::CYCLE_NONE)
    else begin
      fail_count++;
      $error("bus not idle in the cycle after reset");
    end

  mem_only_as_endpoint: assert property (@(posedge clk) disable iff (rst)
    mem_rsp.ack |-> source == nib_regs_pkg::REG_MEM ||
                    destination == nib_regs_pkg::REG_MEM)
    else begin
      fail_count++;
      $error("RAM access completed while memory is no endpoint");
    end

endmodule

bind nib_sequencer nib_core_props u_props (
  .clk         (clk),
  .rst         (rst),
  .host_req    (host_req),
  .host_rsp    (host_rsp),
  .mem_req     (mem_req),
  .mem_rsp     (mem_rsp),
  .cycle       (cycle),
  .source      (source),
  .destination (destination)
);

// ==== dv/nib_core_tb.sv ====
`timescale 1ns/1ps

module nib_core_tb;

  typedef struct packed {
    logic        is_write;
    logic [15:0] word;
    logic [3:0]  expected;
  } golden_entry_t;

  logic                   clk;
  logic                   rst;
  nib_bus_pkg::host_req_t host_req;
  nib_bus_pkg::host_rsp_t host_rsp;

  golden_entry_t golden[$];
  integer        seed;
  int            cycle_count = 0;
  int            cycle_limit = 0;

  nib_clkgen #(
    .PERIOD_NS    (100),
    .RESET_CYCLES (2)
  ) u_clkgen (
    .clk (clk),
    .rst (rst)
  );

  nib_core #(
    .RAM_ADDR_W (12)
  ) UUT (
    .clk      (clk),
    .rst      (rst),
    .host_req (host_req),
    .host_rsp (host_rsp)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped");
  endtask

  // Each W or R line becomes one transaction.
  task automatic load_golden();
    int            fd;
    int            c;
    int            rc;
    int            bad_lines;
    logic [7:0]    ch;
    logic [15:0]   word;
    logic [3:0]    sel;
    logic [3:0]    value;
    golden_entry_t ent;
    bad_lines = 0;
    fd = $fopen("dv/nib_golden.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open the golden file dv/nib_golden.txt");
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        ch = c[7:0];
        if (ch == "#") begin
          while (c != -1 && c != 10) begin
            c = $fgetc(fd);
          end
        end else if (ch == "W") begin
          rc = $fscanf(fd, "%h", word);
          if (rc != 1) begin
            bad_lines = bad_lines + 1;
          end else begin
            ent = '{is_write: 1'b1, word: word, expected: 4'h0};
            golden.push_back(ent);
          end
        end else if (ch == "R") begin
          rc = $fscanf(fd, "%h %h", sel, value);
          if (rc != 2) begin
            bad_lines = bad_lines + 1;
          end else begin
            ent = '{is_write: 1'b0, word: {12'h000, sel}, expected: value};
            golden.push_back(ent);
          end
        end
        if (c != -1) begin
          c = $fgetc(fd);
        end
      end
      $fclose(fd);
      if (bad_lines != 0) begin
        report_failure($sformatf("The golden file holds %0d lines that do not parse",
                                 bad_lines));
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Ack is sampled at the falling edge and the request drops after the edge that takes it.
  task automatic wait_ack(output logic [3:0] data);
    do begin
      @(negedge clk);
    end while (!host_rsp.ack);
    data = host_rsp.dat;
    @(posedge clk);
    #1;
    host_req = '0;
  endtask

  task automatic write_instr(input logic [15:0] word);
    logic [3:0] ignored;
    host_req.cyc = 1'b1;
    host_req.stb = 1'b1;
    host_req.we  = 1'b1;
    host_req.adr = nib_regs_pkg::REG_NONE;
    host_req.dat = word;
    wait_ack(ignored);
  endtask

  task automatic read_check(input logic [3:0] sel, input logic [3:0] expected);
    logic [3:0] got;
    host_req.cyc = 1'b1;
    host_req.stb = 1'b1;
    host_req.we  = 1'b0;
    host_req.adr = nib_regs_pkg::reg_type'(sel);
    host_req.dat = '0;
    wait_ack(got);
    assert (got == expected)
      else report_failure($sformatf("Error: at %0t ns read of reg %h gave %h, expected %h",
                                    $time, sel, got, expected));
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      report_failure($sformatf("Timeout: run went past its limit of %0d cycles",
                               cycle_limit));
    end
  end

  always @(negedge clk) begin
    if (UUT.u_sequencer.u_props.fail_count != 0) begin
      report_failure("A bus handshake assertion in the sequencer failed");
    end
  end

  initial begin
    host_req = '0;
    seed = 45;
    load_golden();
    cycle_limit = 12 * golden.size() + 50;
    @(negedge rst);
    @(posedge clk);
    #1;
    foreach (golden[i]) begin
      idle_cycles($unsigned($random(seed)) % 4);
      if (golden[i].is_write) begin
        write_instr(golden[i].word);
      end else begin
        read_check(golden[i].word[3:0], golden[i].expected);
      end
    end
    @(posedge clk);
    #1;
    if (UUT.u_sequencer.u_props.fail_count != 0) begin
      report_failure("A bus handshake assertion in the sequencer failed");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// ==== dv/nib_golden.txt ====
# W <word>: host write of a micro-instruction, hex {source, destination, immed, alu_op, spare}
# R <reg> <value>: host read of a register code and the expected nibble, both hex
# Immediate loads.
W C050
R 0 5
W C1A0
R 1 A
W C230
R 2 3
W C3C0
R 3 C
# Register to register.
W 0300
R 3 5
W 1200
R 2 A
# X = 0x345.
W C450
W C540
W C630
R 4 5
R 5 4
R 6 3
# Y = 0xFED through TEMPA, TEMPB and A.
W C2D0
W C3E0
W C0F0
W 2700
W 3800
W 0900
R 7 D
R 8 E
R 9 F
# SP = 0xFD.
W CAD0
W CBF0
R A D
R B F
# F + 2 sets carry, the next add takes it.
W C2F0
W C320
W D000
R 0 1
W C230
W C340
W D100
R 1 8
# AND, OR, XOR on C and A.
W C2C0
W C3A0
W D004
R 0 8
W D106
R 1 E
W D008
R 0 6
# 3 - 5 borrows into the next add.
W C230
W C350
W D002
R 0 E
W D100
R 1 9
# Memory round trip at X = 0x345, then an unwritten word.
W C070
W 0E00
W C020
W E100
R 1 7
R 0 2
W C460
W E000
R 0 0
# Read-only endpoints.
R C 0
R E 0
R F 0

// ==== hw/nib_alu.sv ====
`timescale 1ns/1ps

module nib_alu (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              advance,
  input  nib_regs_pkg::alu_op_type          op,
  input  logic [nib_regs_pkg::NIBBLE_W-1:0] a,
  input  logic [nib_regs_pkg::NIBBLE_W-1:0] b,
  output logic [nib_regs_pkg::NIBBLE_W-1:0] result
);

  localparam int W = nib_regs_pkg::NIBBLE_W;

  logic         carry;
  logic [W:0]   sum;

  // Top bit of sum holds carry out, or borrow out for SUB.
  always_comb begin
    case (op)
      nib_regs_pkg::ALU_ADD: sum = {1'b0, a} + {1'b0, b} + {{W{1'b0}}, carry};
      nib_regs_pkg::ALU_SUB: sum = {1'b0, a} - {1'b0, b};
      nib_regs_pkg::ALU_AND: sum = {1'b0, a & b};
      nib_regs_pkg::ALU_OR:  sum = {1'b0, a | b};
      nib_regs_pkg::ALU_XOR: sum = {1'b0, a ^ b};
      nib_regs_pkg::ALU_INC: sum = {1'b0, a} + {{W{1'b0}}, 1'b1};
      default:               sum = '0;
    endcase
  end

  assign result = sum[W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      carry <= 1'b0;
    end else if (advance) begin
      carry <= sum[W];
    end
  end

endmodule

// ==== hw/nib_bus_pkg.sv ====
package nib_bus_pkg;

  // Host port, a micro-instruction on writes and a register select on reads.
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    nib_regs_pkg::reg_type adr;
    logic [15:0]           dat;
  } host_req_t;

  typedef struct packed {
    logic                                ack;
    logic [nib_regs_pkg::NIBBLE_W-1:0]   dat;
  } host_rsp_t;

  // Data RAM port, always addressed by X.
  typedef struct packed {
    logic                                cyc;
    logic                                stb;
    logic                                we;
    logic [11:0]                         adr;
    logic [nib_regs_pkg::NIBBLE_W-1:0]   dat;
  } mem_req_t;

  typedef struct packed {
    logic                                ack;
    logic [nib_regs_pkg::NIBBLE_W-1:0]   dat;
  } mem_rsp_t;

endpackage

// ==== hw/nib_core.sv ====
`timescale 1ns/1ps

module nib_core #(
  parameter int RAM_ADDR_W = 12
) (
  input  logic                   clk,
  input  logic                   rst,
  input  nib_bus_pkg::host_req_t host_req,
  output nib_bus_pkg::host_rsp_t host_rsp
);

  nib_bus_pkg::mem_req_t             mem_req;
  nib_bus_pkg::mem_rsp_t             mem_rsp;
  nib_regs_pkg::cycle_type           cycle;
  nib_regs_pkg::reg_type             source;
  nib_regs_pkg::reg_type             destination;
  nib_regs_pkg::alu_op_type          op;
  logic                              alu_advance;
  logic [nib_regs_pkg::NIBBLE_W-1:0] immed;
  logic [nib_regs_pkg::NIBBLE_W-1:0] mem_data;
  logic [nib_regs_pkg::NIBBLE_W-1:0] read_data;
  logic [nib_regs_pkg::NIBBLE_W-1:0] bus;
  logic [nib_regs_pkg::NIBBLE_W-1:0] temp_a;
  logic [nib_regs_pkg::NIBBLE_W-1:0] temp_b;
  logic [nib_regs_pkg::NIBBLE_W-1:0] alu_result;
  logic [11:0]                       x;

  nib_sequencer u_sequencer (
    .clk         (clk),
    .rst         (rst),
    .host_req    (host_req),
    .host_rsp    (host_rsp),
    .mem_req     (mem_req),
    .mem_rsp     (mem_rsp),
    .cycle       (cycle),
    .source      (source),
    .destination (destination),
    .immed       (immed),
    .op          (op),
    .alu_advance (alu_advance),
    .mem_data    (mem_data),
    .read_data   (read_data),
    .bus         (bus),
    .x           (x)
  );

  nib_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .cycle       (cycle),
    .source      (source),
    .destination (destination),
    .immed       (immed),
    .alu_result  (alu_result),
    .mem_data    (mem_data),
    .read_sel    (host_req.adr),
    .bus         (bus),
    .temp_a      (temp_a),
    .temp_b      (temp_b),
    .x           (x),
    .read_data   (read_data)
  );

  nib_alu u_alu (
    .clk     (clk),
    .rst     (rst),
    .advance (alu_advance),
    .op      (op),
    .a       (temp_a),
    .b       (temp_b),
    .result  (alu_result)
  );

  nib_data_ram #(
    .RAM_ADDR_W (RAM_ADDR_W)
  ) u_data_ram (
    .clk (clk),
    .rst (rst),
    .req (mem_req),
    .rsp (mem_rsp)
  );

endmodule

// ==== hw/nib_data_ram.sv ====
`timescale 1ns/1ps

module nib_data_ram #(
  parameter int RAM_ADDR_W = 12
) (
  input  logic                  clk,
  input  logic                  rst,
  input  nib_bus_pkg::mem_req_t req,
  output nib_bus_pkg::mem_rsp_t rsp
);

  localparam int DEPTH = 2 ** RAM_ADDR_W;

  logic [nib_regs_pkg::NIBBLE_W-1:0] mem [DEPTH] = '{default: '0};

  logic                               ack;
  logic [nib_regs_pkg::NIBBLE_W-1:0]  rd_data;
  logic [RAM_ADDR_W-1:0]              addr;
  logic                               access;

  // Upper X bits drop out with a small RAM.
  assign addr   = req.adr[RAM_ADDR_W-1:0];
  assign access = req.cyc && req.stb && !ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (req.we) begin
        mem[addr] <= req.dat;
      end
      rd_data <= mem[addr];
    end
  end

  assign rsp.ack = ack;
  assign rsp.dat = rd_data;

endmodule

// ==== hw/nib_regs.sv ====
`timescale 1ns/1ps

module nib_regs (
  input  logic                              clk,
  input  logic                              rst,
  input  nib_regs_pkg::cycle_type           cycle,
  input  nib_regs_pkg::reg_type             source,
  input  nib_regs_pkg::reg_type             destination,
  input  logic [nib_regs_pkg::NIBBLE_W-1:0] immed,
  input  logic [nib_regs_pkg::NIBBLE_W-1:0] alu_result,
  input  logic [nib_regs_pkg::NIBBLE_W-1:0] mem_data,
  input  nib_regs_pkg::reg_type             read_sel,
  output logic [nib_regs_pkg::NIBBLE_W-1:0] bus,
  output logic [nib_regs_pkg::NIBBLE_W-1:0] temp_a,
  output logic [nib_regs_pkg::NIBBLE_W-1:0] temp_b,
  output logic [11:0]                       x,
  output logic [nib_regs_pkg::NIBBLE_W-1:0] read_data
);

  localparam int NUM_NIBBLES = 12;

  // One nibble per register code: A, B, TEMPA, TEMPB, X, Y, SP.
  logic [NUM_NIBBLES-1:0][nib_regs_pkg::NIBBLE_W-1:0] file;

  logic write_en;

  assign write_en = (cycle == nib_regs_pkg::CYCLE_REG_WRITE) &&
                    (destination < nib_regs_pkg::REG_IMM);

  // Bus source select.
  always_comb begin
    case (source)
      nib_regs_pkg::REG_IMM:  bus = immed;
      nib_regs_pkg::REG_ALU:  bus = alu_result;
      nib_regs_pkg::REG_MEM:  bus = mem_data;
      nib_regs_pkg::REG_NONE: bus = '0;
      default:                bus = file[source];
    endcase
  end

  // Host readback, non-register endpoints read as zero except the ALU.
  always_comb begin
    case (read_sel)
      nib_regs_pkg::REG_ALU:  read_data = alu_result;
      nib_regs_pkg::REG_IMM,
      nib_regs_pkg::REG_MEM,
      nib_regs_pkg::REG_NONE: read_data = '0;
      default:                read_data = file[read_sel];
    endcase
  end

  // Destination takes the bus on the edge that ends WRITE.
  always_ff @(posedge clk) begin
    if (rst) begin
      file <= '0;
    end else if (write_en) begin
      file[destination] <= bus;
    end
  end

  assign temp_a = file[nib_regs_pkg::REG_TEMPA];
  assign temp_b = file[nib_regs_pkg::REG_TEMPB];

  assign x = {file[nib_regs_pkg::REG_XP],
              file[nib_regs_pkg::REG_XH],
              file[nib_regs_pkg::REG_XL]};

endmodule

// ==== hw/nib_regs_pkg.sv ====
package nib_regs_pkg;

  localparam int NIBBLE_W = 4;

  // Bus endpoints, numbered so registers fill codes 0 to 11.
  typedef enum logic [3:0] {
    REG_A,
    REG_B,
    REG_TEMPA,
    REG_TEMPB,
    REG_XL,
    REG_XH,
    REG_XP,
    REG_YL,
    REG_YH,
    REG_YP,
    REG_SPL,
    REG_SPH,
    REG_IMM,
    REG_ALU,
    REG_MEM,
    REG_NONE
  } reg_type;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_INC
  } alu_op_type;

  typedef struct packed {
    reg_type               source;
    reg_type               destination;
    logic [NIBBLE_W-1:0]   immed;
    alu_op_type            alu_op;
    logic                  spare;
  } micro_instr_t;

  typedef enum logic [1:0] {
    CYCLE_NONE,
    CYCLE_REG_FETCH,
    CYCLE_REG_WRITE
  } cycle_type;

endpackage

// ==== hw/nib_sequencer.sv ====
`timescale 1ns/1ps

module nib_sequencer (
  input  logic                              clk,
  input  logic                              rst,
  input  nib_bus_pkg::host_req_t            host_req,
  output nib_bus_pkg::host_rsp_t            host_rsp,
  output nib_bus_pkg::mem_req_t             mem_req,
  input  nib_bus_pkg::mem_rsp_t             mem_rsp,
  output nib_regs_pkg::cycle_type           cycle,
  output nib_regs_pkg::reg_type             source,
  output nib_regs_pkg::reg_type             destination,
  output logic [nib_regs_pkg::NIBBLE_W-1:0] immed,
  output nib_regs_pkg::alu_op_type          op,
  output logic                              alu_advance,
  output logic [nib_regs_pkg::NIBBLE_W-1:0] mem_data,
  input  logic [nib_regs_pkg::NIBBLE_W-1:0] read_data,
  input  logic [nib_regs_pkg::NIBBLE_W-1:0] bus,
  input  logic [11:0]                       x
);

  nib_regs_pkg::micro_instr_t              incoming;
  nib_regs_pkg::micro_instr_t              instr;
  logic                                    host_sel;
  logic                                    read_ack;
  logic [nib_regs_pkg::NIBBLE_W-1:0]       read_q;
  logic                                    mem_stb;
  logic                                    mem_we;

  assign incoming = host_req.dat;
  assign host_sel = host_req.cyc && host_req.stb;

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle    <= nib_regs_pkg::CYCLE_NONE;
      read_ack <= 1'b0;
      mem_stb  <= 1'b0;
      mem_we   <= 1'b0;
    end else begin
      read_ack <= 1'b0;
      case (cycle)
        nib_regs_pkg::CYCLE_NONE: begin
          // The !read_ack term keeps a finishing read from being taken twice.
          if (host_sel && !read_ack) begin
            if (host_req.we) begin
              cycle   <= nib_regs_pkg::CYCLE_REG_FETCH;
              mem_stb <= (incoming.source == nib_regs_pkg::REG_MEM) ||
                         (incoming.destination == nib_regs_pkg::REG_MEM);
              mem_we  <= (incoming.source != nib_regs_pkg::REG_MEM);
            end else begin
              read_ack <= 1'b1;
            end
          end
        end
        nib_regs_pkg::CYCLE_REG_FETCH: begin
          // Stay in FETCH until the RAM answers.
          if (!mem_stb) begin
            cycle <= nib_regs_pkg::CYCLE_REG_WRITE;
          end else if (mem_rsp.ack) begin
            mem_stb <= 1'b0;
            cycle   <= nib_regs_pkg::CYCLE_REG_WRITE;
          end
        end
        default: cycle <= nib_regs_pkg::CYCLE_NONE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cycle == nib_regs_pkg::CYCLE_NONE && host_sel && host_req.we) begin
      instr <= incoming;
    end
    if (cycle == nib_regs_pkg::CYCLE_NONE && host_sel && !host_req.we) begin
      read_q <= read_data;
    end
    if (mem_stb && mem_rsp.ack) begin
      mem_data <= mem_rsp.dat;
    end
  end

  assign source      = instr.source;
  assign destination = instr.destination;
  assign immed       = instr.immed;
  assign op          = instr.alu_op;

  // Carry moves only when an arithmetic result is written somewhere.
  assign alu_advance = (cycle == nib_regs_pkg::CYCLE_REG_WRITE) &&
                       (instr.source == nib_regs_pkg::REG_ALU) &&
                       (instr.alu_op inside {nib_regs_pkg::ALU_ADD,
                                             nib_regs_pkg::ALU_SUB,
                                             nib_regs_pkg::ALU_INC});

  assign host_rsp.ack = read_ack || (cycle == nib_regs_pkg::CYCLE_REG_WRITE);
  assign host_rsp.dat = read_q;

  assign mem_req.cyc = mem_stb;
  assign mem_req.stb = mem_stb;
  assign mem_req.we  = mem_we;
  assign mem_req.adr = x;
  assign mem_req.dat = bus;

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module nib_core_tb -f build.f -o nib_core_sim

output=$(./obj_dir/nib_core_sim +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'PASS: all tests'; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation did not report a pass"
exit 1
